// ==== verilog/rename_settings.svh ====
// ------------------------------------------------------------
// Rename stage settings
// Slot counts, register counts and index widths
// ------------------------------------------------------------
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Superscalar widths
`define DP_NUM          2
`define CDB_NUM         2
`define RT_NUM          2

// Register file sizes
`define ARCH_REG_NUM    32
`define PHYS_REG_NUM    64

// Index widths
`define ARCH_IDX_W      5
`define TAG_W           6

// Tags not held by the committed map at any time
`define FREE_NUM        (`PHYS_REG_NUM - `ARCH_REG_NUM)

// Hardwired zero register
`define ZERO_REG        0

`endif

// ==== verilog/rename_pkg.sv ====
// ------------------------------------------------------------
// Rename package
// Packed structs passed between the rename blocks
// ------------------------------------------------------------
`default_nettype none

`include "rename_settings.svh"

package rename_pkg;

    // One dispatched instruction, as seen at the stage input
    typedef struct packed {
        logic                   valid;
        logic                   wr_en;
        logic [`ARCH_IDX_W-1:0] rd;
        logic [`ARCH_IDX_W-1:0] rs1;
        logic [`ARCH_IDX_W-1:0] rs2;
    } dp_req_t;

    // Dispatch after allocation
    // wr_en is the granted write, tag the new physical register
    typedef struct packed {
        logic                   wr_en;
        logic [`ARCH_IDX_W-1:0] rd;
        logic [`ARCH_IDX_W-1:0] rs1;
        logic [`ARCH_IDX_W-1:0] rs2;
        logic [`TAG_W-1:0]      tag;
    } dp_mt_t;

    // Renamed sources plus the mapping that rd replaces
    typedef struct packed {
        logic [`TAG_W-1:0] tag1;
        logic              tag1_ready;
        logic [`TAG_W-1:0] tag2;
        logic              tag2_ready;
        logic [`TAG_W-1:0] tag_old;
    } mt_dp_t;

    // Result broadcast channel
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
    } cdb_t;

    // Retiring instruction
    typedef struct packed {
        logic                   valid;
        logic [`ARCH_IDX_W-1:0] rd;
        logic [`TAG_W-1:0]      tag;
        logic [`TAG_W-1:0]      tag_old;
    } retire_t;

    // Committed mapping of one architectural register
    typedef struct packed {
        logic [`TAG_W-1:0] amt_tag;
    } amt_entry_t;

endpackage

`default_nettype wire

// ==== verilog/free_list.sv ====
// ------------------------------------------------------------
// Free list
// Circular buffer of free physical tags
// Allocates at the head, frees at the tail, rolls back to commit
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module free_list (
    input  wire logic                                  clk_i,
    input  wire logic                                  rst_i,
    input  wire logic                                  rollback_i,
    input  wire rename_pkg::dp_req_t   [`DP_NUM-1:0]   dp_req_i,
    input  wire rename_pkg::retire_t   [`RT_NUM-1:0]   retire_i,
    output rename_pkg::dp_mt_t         [`DP_NUM-1:0]   dp_mt_o,
    output logic                                       stall_o
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`FREE_NUM);
    localparam int CNT_W = $clog2(`FREE_NUM + 1);

    // Tag storage and pointers
    logic [`TAG_W-1:0] free_buf [`FREE_NUM];
    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [PTR_W-1:0]  commit_head;
    logic [CNT_W-1:0]  free_cnt;

    // Allocation side
    logic [`DP_NUM-1:0] req;
    logic [PTR_W-1:0]   req_ofs [`DP_NUM];
    logic [CNT_W-1:0]   num_req;
    logic [CNT_W-1:0]   num_grant;

    // Retire side
    logic [PTR_W-1:0]   ret_ofs [`RT_NUM];
    logic [CNT_W-1:0]   num_ret;

    // ----------------------------------------------------------
    // Allocation, all or nothing per group
    // ----------------------------------------------------------
    always_comb begin
        num_req = '0;
        for (int d = 0; d < `DP_NUM; d++) begin
            req[d]     = dp_req_i[d].valid && dp_req_i[d].wr_en
                         && (dp_req_i[d].rd != `ZERO_REG);
            // Position behind the head, counting older requesters only
            req_ofs[d] = num_req[PTR_W-1:0];
            num_req    = num_req + CNT_W'(req[d]);
        end

        stall_o   = (num_req > free_cnt);
        num_grant = stall_o ? '0 : num_req;

        for (int d = 0; d < `DP_NUM; d++) begin
            dp_mt_o[d].wr_en = req[d] && !stall_o;
            dp_mt_o[d].rd    = dp_req_i[d].rd;
            dp_mt_o[d].rs1   = dp_req_i[d].rs1;
            dp_mt_o[d].rs2   = dp_req_i[d].rs2;
            dp_mt_o[d].tag   = dp_mt_o[d].wr_en ? free_buf[head + req_ofs[d]] : '0;
        end
    end

    // Retire slots free in order at the tail
    always_comb begin
        num_ret = '0;
        for (int r = 0; r < `RT_NUM; r++) begin
            ret_ofs[r] = num_ret[PTR_W-1:0];
            num_ret    = num_ret + CNT_W'(retire_i[r].valid);
        end
    end

    // ----------------------------------------------------------
    // Buffer contents
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Upper half of the physical file starts free
            for (int t = `ARCH_REG_NUM; t < `PHYS_REG_NUM; t++) begin
                free_buf[t - `ARCH_REG_NUM] <= t[`TAG_W-1:0];
            end
        end else begin
            // Overwrites the slot of the allocation that is retiring
            for (int r = 0; r < `RT_NUM; r++) begin
                if (retire_i[r].valid) begin
                    free_buf[tail + ret_ofs[r]] <= retire_i[r].tag_old;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Pointers and count
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head        <= '0;
            tail        <= '0;
            commit_head <= '0;
            free_cnt    <= CNT_W'(`FREE_NUM);
        end else begin
            // Each retire once consumed one allocation
            tail        <= tail + num_ret[PTR_W-1:0];
            commit_head <= commit_head + num_ret[PTR_W-1:0];
            if (rollback_i) begin
                // In-flight tags are still stored after the commit head
                head     <= commit_head + num_ret[PTR_W-1:0];
                free_cnt <= CNT_W'(`FREE_NUM);
            end else begin
                head     <= head + num_grant[PTR_W-1:0];
                free_cnt <= free_cnt + num_ret - num_grant;
            end
        end
    end

    // Retires never outnumber earlier grants
    cnt_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        free_cnt <= CNT_W'(`FREE_NUM))
        else $error("free_list: free count above capacity");

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
// ------------------------------------------------------------
// Map table
// Speculative arch to physical map, two-wide read and write
// Same-group bypass, CDB wakeup, restore from AMT on rollback
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module map_table (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_i,
    input  wire logic                                       rollback_i,
    input  wire rename_pkg::dp_mt_t     [`DP_NUM-1:0]       dp_mt_i,
    input  wire rename_pkg::cdb_t       [`CDB_NUM-1:0]      cdb_i,
    input  wire rename_pkg::amt_entry_t [`ARCH_REG_NUM-1:0] amt_i,
    output rename_pkg::mt_dp_t          [`DP_NUM-1:0]       mt_dp_o
);
    import rename_pkg::*;

    // Current mapping of one register and whether its value exists
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic              tag_ready;
    } mt_entry_t;

    mt_entry_t [`ARCH_REG_NUM-1:0] mt_entry;
    mt_entry_t [`ARCH_REG_NUM-1:0] mt_entry_next;

    // ----------------------------------------------------------
    // Read port, one per dispatch slot
    // ----------------------------------------------------------
    always_comb begin
        for (int d = 0; d < `DP_NUM; d++) begin
            // Stored mapping first
            mt_dp_o[d].tag1       = mt_entry[dp_mt_i[d].rs1].tag;
            mt_dp_o[d].tag1_ready = mt_entry[dp_mt_i[d].rs1].tag_ready;
            mt_dp_o[d].tag2       = mt_entry[dp_mt_i[d].rs2].tag;
            mt_dp_o[d].tag2_ready = mt_entry[dp_mt_i[d].rs2].tag_ready;
            mt_dp_o[d].tag_old    = mt_entry[dp_mt_i[d].rd].tag;

            // Result arriving this cycle makes the source ready
            for (int c = 0; c < `CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].tag != '0)) begin
                    if (cdb_i[c].tag == mt_dp_o[d].tag1) begin
                        mt_dp_o[d].tag1_ready = 1'b1;
                    end
                    if (cdb_i[c].tag == mt_dp_o[d].tag2) begin
                        mt_dp_o[d].tag2_ready = 1'b1;
                    end
                end
            end

            // Older slots in the group rename ahead of this one
            // Walking oldest to newest leaves the closest writer in place
            for (int o = 0; o < d; o++) begin
                if (dp_mt_i[o].wr_en) begin
                    if ((dp_mt_i[d].rs1 != `ZERO_REG) && (dp_mt_i[d].rs1 == dp_mt_i[o].rd)) begin
                        mt_dp_o[d].tag1       = dp_mt_i[o].tag;
                        mt_dp_o[d].tag1_ready = 1'b0;
                    end
                    if ((dp_mt_i[d].rs2 != `ZERO_REG) && (dp_mt_i[d].rs2 == dp_mt_i[o].rd)) begin
                        mt_dp_o[d].tag2       = dp_mt_i[o].tag;
                        mt_dp_o[d].tag2_ready = 1'b0;
                    end
                    // Previous mapping of rd is the older slot's new tag
                    if ((dp_mt_i[d].rd != `ZERO_REG) && (dp_mt_i[d].rd == dp_mt_i[o].rd)) begin
                        mt_dp_o[d].tag_old = dp_mt_i[o].tag;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Next state of every entry
    // ----------------------------------------------------------
    always_comb begin
        mt_entry_next = mt_entry;
        // Entry 0 is left alone, it never gets renamed
        for (int e = 1; e < `ARCH_REG_NUM; e++) begin
            // Wakeup from any CDB channel
            for (int c = 0; c < `CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].tag != '0)
                        && (cdb_i[c].tag == mt_entry[e].tag)) begin
                    mt_entry_next[e].tag_ready = 1'b1;
                end
            end
            // New mapping, youngest slot applied last
            for (int d = 0; d < `DP_NUM; d++) begin
                if (dp_mt_i[d].wr_en && (dp_mt_i[d].rd == e[`ARCH_IDX_W-1:0])) begin
                    mt_entry_next[e].tag       = dp_mt_i[d].tag;
                    mt_entry_next[e].tag_ready = 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Entry registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Identity map, everything ready
            for (int e = 0; e < `ARCH_REG_NUM; e++) begin
                mt_entry[e].tag       <= e[`TAG_W-1:0];
                mt_entry[e].tag_ready <= 1'b1;
            end
        end else if (rollback_i) begin
            // Committed state only, dispatch of this cycle dropped
            for (int e = 0; e < `ARCH_REG_NUM; e++) begin
                mt_entry[e].tag       <= amt_i[e].amt_tag;
                mt_entry[e].tag_ready <= 1'b1;
            end
        end else begin
            mt_entry <= mt_entry_next;
        end
    end

    // Holds only while the free list never grants rd 0 and the AMT keeps entry 0
    zero_entry_fixed: assert property (@(posedge clk_i) disable iff (rst_i)
        (mt_entry[0].tag == '0) && mt_entry[0].tag_ready)
        else $error("map_table: register 0 lost its fixed mapping");

endmodule

`default_nettype wire

// ==== verilog/arch_map_table.sv ====
// ------------------------------------------------------------
// Architectural map table
// Committed arch to physical map, written at retirement
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module arch_map_table (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_i,
    input  wire rename_pkg::retire_t    [`RT_NUM-1:0]       retire_i,
    output rename_pkg::amt_entry_t      [`ARCH_REG_NUM-1:0] amt_o
);
    import rename_pkg::*;

    // ----------------------------------------------------------
    // Committed map registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Register n lives in tag n out of reset
            for (int a = 0; a < `ARCH_REG_NUM; a++) begin
                amt_o[a].amt_tag <= a[`TAG_W-1:0];
            end
        end else begin
            // Later slot is younger, its write lands last
            for (int r = 0; r < `RT_NUM; r++) begin
                if (retire_i[r].valid) begin
                    amt_o[retire_i[r].rd].amt_tag <= retire_i[r].tag;
                end
            end
        end
    end

    // Register 0 is never renamed, so it never retires
    for (genvar r = 0; r < `RT_NUM; r++) begin : g_rt_chk
        rd_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
            retire_i[r].valid |-> (retire_i[r].rd != `ZERO_REG))
            else $error("arch_map_table: retire slot %0d names register 0", r);
    end

endmodule

`default_nettype wire

// ==== verilog/rename_top.sv ====
// ------------------------------------------------------------
// Rename stage top
// Free list, map table and architectural map table
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module rename_top (
    input  wire logic                                  clk_i,
    input  wire logic                                  rst_i,
    input  wire logic                                  rollback_i,
    input  wire rename_pkg::dp_req_t   [`DP_NUM-1:0]   dp_req_i,
    input  wire rename_pkg::cdb_t      [`CDB_NUM-1:0]  cdb_i,
    input  wire rename_pkg::retire_t   [`RT_NUM-1:0]   retire_i,
    output rename_pkg::dp_mt_t         [`DP_NUM-1:0]   alloc_o,
    output rename_pkg::mt_dp_t         [`DP_NUM-1:0]   mt_dp_o,
    output logic                                       stall_o
);
    import rename_pkg::*;

    // Granted dispatch group, free list to map table
    dp_mt_t     [`DP_NUM-1:0]       dp_mt;
    // Committed map, restored on rollback
    amt_entry_t [`ARCH_REG_NUM-1:0] amt;

    // ----------------------------------------------------------
    // Block instances
    // ----------------------------------------------------------
    free_list i_free_list (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rollback_i (rollback_i),
        .dp_req_i   (dp_req_i),
        .retire_i   (retire_i),
        .dp_mt_o    (dp_mt),
        .stall_o    (stall_o)
    );

    map_table i_map_table (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rollback_i (rollback_i),
        .dp_mt_i    (dp_mt),
        .cdb_i      (cdb_i),
        .amt_i      (amt),
        .mt_dp_o    (mt_dp_o)
    );

    arch_map_table i_arch_map_table (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .retire_i   (retire_i),
        .amt_o      (amt)
    );

    // New tags go out with the grant
    assign alloc_o = dp_mt;

endmodule

`default_nettype wire

// ==== verif/rename_tb.sv ====
// ------------------------------------------------------------
// Rename stage testbench
// Reference model with map, AMT, free FIFO and in-flight list
// Concurrent assertions compare every output with the model
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;

    logic                          clk_i;
    logic                          rst_i;
    logic                          rollback_i;
    dp_req_t [`DP_NUM-1:0]         dp_req_i;
    cdb_t    [`CDB_NUM-1:0]        cdb_i;
    retire_t [`RT_NUM-1:0]         retire_i;
    dp_mt_t  [`DP_NUM-1:0]         alloc_o;
    mt_dp_t  [`DP_NUM-1:0]         mt_dp_o;
    logic                          stall_o;

    // ----------------------------------------------------------
    // Reference model state
    // ----------------------------------------------------------
    logic [`TAG_W-1:0]      m_tag   [`ARCH_REG_NUM];
    logic                   m_rdy   [`ARCH_REG_NUM];
    logic [`TAG_W-1:0]      m_amt   [`ARCH_REG_NUM];
    // Free tags, oldest first
    logic [`TAG_W-1:0]      fr      [`FREE_NUM];
    int                     fr_n;
    // In-flight instructions in program order
    logic [`ARCH_IDX_W-1:0] rob_rd  [`FREE_NUM];
    logic [`TAG_W-1:0]      rob_tag [`FREE_NUM];
    logic [`TAG_W-1:0]      rob_old [`FREE_NUM];
    int                     rob_n;

    dp_mt_t [`DP_NUM-1:0]   exp_alloc;
    mt_dp_t [`DP_NUM-1:0]   exp_mt;
    logic                   exp_stall;

    logic [15:0]            lfsr;
    int                     timeout_cnt;

    rename_top i_rename_top (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rollback_i (rollback_i),
        .dp_req_i   (dp_req_i),
        .cdb_i      (cdb_i),
        .retire_i   (retire_i),
        .alloc_o    (alloc_o),
        .mt_dp_o    (mt_dp_o),
        .stall_o    (stall_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // Expected outputs from model state and current inputs
    // ----------------------------------------------------------
    always_comb begin : expect_blk
        int   nreq;
        int   ofs [`DP_NUM];
        logic req [`DP_NUM];
        nreq = 0;
        for (int d = 0; d < `DP_NUM; d++) begin
            req[d] = dp_req_i[d].valid && dp_req_i[d].wr_en && (dp_req_i[d].rd != 0);
            ofs[d] = nreq;
            nreq   = nreq + int'(req[d]);
        end
        // All or nothing when tags run short
        exp_stall = (nreq > fr_n);
        for (int d = 0; d < `DP_NUM; d++) begin
            exp_alloc[d].wr_en = req[d] && !exp_stall;
            exp_alloc[d].rd    = dp_req_i[d].rd;
            exp_alloc[d].rs1   = dp_req_i[d].rs1;
            exp_alloc[d].rs2   = dp_req_i[d].rs2;
            exp_alloc[d].tag   = exp_alloc[d].wr_en ? fr[ofs[d]] : '0;
        end
        for (int d = 0; d < `DP_NUM; d++) begin
            exp_mt[d].tag1       = m_tag[dp_req_i[d].rs1];
            exp_mt[d].tag1_ready = m_rdy[dp_req_i[d].rs1];
            exp_mt[d].tag2       = m_tag[dp_req_i[d].rs2];
            exp_mt[d].tag2_ready = m_rdy[dp_req_i[d].rs2];
            exp_mt[d].tag_old    = m_tag[dp_req_i[d].rd];
            for (int c = 0; c < `CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].tag != 0)) begin
                    if (cdb_i[c].tag == exp_mt[d].tag1) exp_mt[d].tag1_ready = 1'b1;
                    if (cdb_i[c].tag == exp_mt[d].tag2) exp_mt[d].tag2_ready = 1'b1;
                end
            end
            // Older writer in the same group
            for (int o = 0; o < d; o++) begin
                if (exp_alloc[o].wr_en) begin
                    if ((dp_req_i[d].rs1 != 0) && (dp_req_i[d].rs1 == exp_alloc[o].rd)) begin
                        exp_mt[d].tag1       = exp_alloc[o].tag;
                        exp_mt[d].tag1_ready = 1'b0;
                    end
                    if ((dp_req_i[d].rs2 != 0) && (dp_req_i[d].rs2 == exp_alloc[o].rd)) begin
                        exp_mt[d].tag2       = exp_alloc[o].tag;
                        exp_mt[d].tag2_ready = 1'b0;
                    end
                    if ((dp_req_i[d].rd != 0) && (dp_req_i[d].rd == exp_alloc[o].rd)) begin
                        exp_mt[d].tag_old = exp_alloc[o].tag;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
        $display("tests failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    stall_chk: assert property (@(posedge clk_i) disable iff (rst_i) stall_o == exp_stall)
        else report_mismatch("stall_o", 64'($sampled(stall_o)), 64'($sampled(exp_stall)));

    alloc_chk: assert property (@(posedge clk_i) disable iff (rst_i) alloc_o == exp_alloc)
        else report_mismatch("alloc_o", 64'($sampled(alloc_o)), 64'($sampled(exp_alloc)));

    mt_chk: assert property (@(posedge clk_i) disable iff (rst_i) mt_dp_o == exp_mt)
        else report_mismatch("mt_dp_o", 64'($sampled(mt_dp_o)), 64'($sampled(exp_mt)));

    // ----------------------------------------------------------
    // Model update, once per rising edge
    // ----------------------------------------------------------
    task automatic reset_model();
        for (int e = 0; e < `ARCH_REG_NUM; e++) begin
            m_tag[e] = `TAG_W'(e);
            m_rdy[e] = 1'b1;
            m_amt[e] = `TAG_W'(e);
        end
        for (int i = 0; i < `FREE_NUM; i++) fr[i] = `TAG_W'(`ARCH_REG_NUM + i);
        fr_n  = `FREE_NUM;
        rob_n = 0;
    endtask

    task automatic update_model();
        dp_mt_t [`DP_NUM-1:0] a;
        mt_dp_t [`DP_NUM-1:0] t;
        int                   ng;
        logic [`TAG_W-1:0]    merged [`FREE_NUM];
        a  = exp_alloc;
        t  = exp_mt;
        ng = 0;
        if (rollback_i) begin
            for (int e = 0; e < `ARCH_REG_NUM; e++) begin
                m_tag[e] = m_amt[e];
                m_rdy[e] = 1'b1;
            end
        end else begin
            for (int e = 1; e < `ARCH_REG_NUM; e++) begin
                for (int c = 0; c < `CDB_NUM; c++) begin
                    if (cdb_i[c].valid && (cdb_i[c].tag != 0) && (cdb_i[c].tag == m_tag[e]))
                        m_rdy[e] = 1'b1;
                end
            end
            for (int d = 0; d < `DP_NUM; d++) begin
                if (a[d].wr_en) begin
                    m_tag[a[d].rd] = a[d].tag;
                    m_rdy[a[d].rd] = 1'b0;
                    rob_rd[rob_n]  = a[d].rd;
                    rob_tag[rob_n] = a[d].tag;
                    rob_old[rob_n] = t[d].tag_old;
                    rob_n++;
                    ng++;
                end
            end
            // Granted tags leave the front of the free FIFO
            for (int i = 0; i + ng < fr_n; i++) fr[i] = fr[i + ng];
            fr_n = fr_n - ng;
        end
        for (int r = 0; r < `RT_NUM; r++) begin
            if (retire_i[r].valid) begin
                m_amt[retire_i[r].rd] = retire_i[r].tag;
                for (int i = 0; i + 1 < rob_n; i++) begin
                    rob_rd[i]  = rob_rd[i + 1];
                    rob_tag[i] = rob_tag[i + 1];
                    rob_old[i] = rob_old[i + 1];
                end
                rob_n--;
                fr[fr_n] = retire_i[r].tag_old;
                fr_n++;
            end
        end
        if (rollback_i) begin
            // In-flight tags go back ahead of the free ones
            for (int i = 0; i < rob_n; i++) merged[i] = rob_tag[i];
            for (int i = 0; i < fr_n; i++) merged[rob_n + i] = fr[i];
            fr    = merged;
            fr_n  = `FREE_NUM;
            rob_n = 0;
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic tick();
        @(posedge clk_i);
        if (rst_i) reset_model();
        else update_model();
    endtask

    task automatic idle_inputs();
        dp_req_i   <= '0;
        cdb_i      <= '0;
        retire_i   <= '0;
        rollback_i <= 1'b0;
    endtask

    task automatic set_slot(input int d, input logic w, input int rd, input int rs1,
                            input int rs2);
        dp_req_i[d] <= {1'b1, w, `ARCH_IDX_W'(rd), `ARCH_IDX_W'(rs1), `ARCH_IDX_W'(rs2)};
    endtask

    task automatic retire_oldest(input int n);
        for (int r = 0; r < n; r++) begin
            retire_i[r] <= {1'b1, rob_rd[r], rob_tag[r], rob_old[r]};
        end
    endtask

    task automatic random_step();
        int v;
        int w;
        int rd;
        int rs1;
        int rs2;
        int i;
        idle_inputs();
        for (int d = 0; d < `DP_NUM; d++) begin
            take_bits(1, v);
            take_bits(1, w);
            take_bits(5, rd);
            take_bits(5, rs1);
            take_bits(5, rs2);
            if (v != 0) set_slot(d, w[0], rd, rs1, rs2);
        end
        // Broadcast mostly tags that are in flight
        for (int c = 0; c < `CDB_NUM; c++) begin
            take_bits(1, v);
            if (v != 0 && rob_n > 0) begin
                take_bits(5, i);
                cdb_i[c] <= {1'b1, rob_tag[i % rob_n]};
            end else if (v != 0) begin
                take_bits(6, i);
                cdb_i[c] <= {1'b1, `TAG_W'(i)};
            end
        end
        take_bits(7, v);
        if (v == 0) begin
            rollback_i <= 1'b1;
        end else begin
            take_bits(2, v);
            retire_oldest(((v % 3) < rob_n) ? (v % 3) : rob_n);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        lfsr       = 16'd43;
        rst_i      = 1'b1;
        rollback_i = 1'b0;
        dp_req_i   = '0;
        cdb_i      = '0;
        retire_i   = '0;
        repeat (5) tick();
        rst_i <= 1'b0;

        // Identity map readout
        for (int k = 0; k < 16; k++) begin
            tick();
            idle_inputs();
            set_slot(0, 1'b0, 0, 2 * k, 2 * k + 1);
            set_slot(1, 1'b0, 0, 2 * k + 1, 2 * k);
        end
        // First grants, slot 1 reads slot 0's rd
        tick();
        idle_inputs();
        set_slot(0, 1'b1, 1, 3, 4);
        set_slot(1, 1'b1, 2, 1, 0);
        // Both slots write r5, register 0 never renamed
        tick();
        idle_inputs();
        set_slot(0, 1'b1, 5, 5, 0);
        set_slot(1, 1'b1, 5, 5, 5);
        tick();
        idle_inputs();
        set_slot(0, 1'b1, 0, 0, 0);
        set_slot(1, 1'b1, 0, 0, 0);
        // Wakeup, then the ready bit persists
        tick();
        idle_inputs();
        cdb_i[0] <= {1'b1, rob_tag[0]};
        cdb_i[1] <= {1'b1, rob_tag[rob_n - 1]};
        set_slot(0, 1'b0, 0, 1, 5);
        set_slot(1, 1'b0, 0, 2, 5);
        tick();
        idle_inputs();
        set_slot(0, 1'b0, 0, 1, 5);
        set_slot(1, 1'b0, 0, 2, 5);

        // Exhaustion with an odd count left over
        // Slot 1 sits out the first group, so one tag remains for a pair
        for (int k = 0; k < 20; k++) begin
            tick();
            idle_inputs();
            set_slot(0, 1'b1, 8 + k % 8, 1, 2);
            set_slot(1, k != 0, 16 + k % 8, 3, 4);
        end
        for (int k = 0; k < 4; k++) begin
            tick();
            idle_inputs();
            retire_oldest(2);
        end
        for (int k = 0; k < 6; k++) begin
            tick();
            idle_inputs();
            set_slot(0, 1'b1, 9, 8, 16);
            set_slot(1, 1'b1, 17, 9, 9);
        end

        // Random traffic with occasional rollback
        for (int k = 0; k < 1300; k++) begin
            tick();
            random_step();
        end
        tick();
        idle_inputs();
        rollback_i <= 1'b1;
        for (int k = 0; k < 16; k++) begin
            tick();
            idle_inputs();
            set_slot(0, 1'b0, 0, 2 * k, 2 * k + 1);
            set_slot(1, 1'b0, 0, 2 * k + 1, 2 * k);
        end
        // A full free list after rollback
        for (int k = 0; k < 16; k++) begin
            tick();
            idle_inputs();
            set_slot(0, 1'b1, 1 + k, 2, 3);
            set_slot(1, 1'b1, 17 + k % 15, 1 + k, 4);
        end
        tick();
        idle_inputs();
        tick();
        @(negedge clk_i);
        $display("all tests passed");
        $finish;
    end

    // Watchdog
    initial begin
        timeout_cnt = 0;
        while (timeout_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            timeout_cnt++;
        end
        $display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/arch_map_table.sv
verilog/rename_top.sv
verif/rename_tb.sv

// ==== Makefile ====
# Verilator build and run for the rename stage testbench

VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
